//--- Bender.yml
package:
  name: mem_scheduler

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mem_sched_pkg.sv
      - rtl/req_queue.sv
      - rtl/slot_table.sv
      - rtl/batch_issue.sv
      - rtl/rsp_assembler.sv
      - rtl/mem_scheduler.sv
  - target: test
    include_dirs:
      - rtl
      - tb
    files:
      - tb/tb_mem_scheduler.sv

//--- rtl/batch_issue.sv
// Splits the head request into memory beats of two lanes each.
// Batches with no active lane are skipped; the beat sits in a one-entry
// output register until memory takes it.
`timescale 1ns/1ps
`include "mem_sched_settings.svh"

module batch_issue
    import mem_sched_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        head_valid,
    input  queued_req_t head,
    output logic        head_ready,
    output logic        mem_req_valid,
    output mem_req_t    mem_req,
    input  logic        mem_req_ready
);
    logic [`MS_BATCHES-1:0] batch_valid;
    batch_idx_t batch_idx;
    batch_idx_t sel;
    batch_idx_t last;
    logic found;
    logic load;
    mem_req_t next_req;

    always_comb begin
        for (int b = 0; b < `MS_BATCHES; b++) begin
            batch_valid[b] = |head.mask[b*`MS_MEM_CHANNELS +: `MS_MEM_CHANNELS];
        end
    end

    // First non-empty batch from the counter on, and the last non-empty one
    always_comb begin
        sel   = batch_idx;
        found = 1'b0;
        last  = '0;
        for (int b = 0; b < `MS_BATCHES; b++) begin
            if (batch_valid[b]) begin
                last = batch_idx_t'(b);
                if (!found && batch_idx_t'(b) >= batch_idx) begin
                    sel   = batch_idx_t'(b);
                    found = 1'b1;
                end
            end
        end
    end

    always_comb begin
        next_req.rw  = head.rw;
        next_req.tag = {head.slot, sel};
        for (int c = 0; c < `MS_MEM_CHANNELS; c++) begin
            next_req.mask[c]   = head.mask[sel*`MS_MEM_CHANNELS + c];
            next_req.byteen[c] = head.byteen[sel*`MS_MEM_CHANNELS + c];
            next_req.addr[c]   = head.addr[sel*`MS_MEM_CHANNELS + c];
            next_req.data[c]   = head.data[sel*`MS_MEM_CHANNELS + c];
        end
    end

    // Register is free when empty or draining this cycle
    assign load       = head_valid && found && (!mem_req_valid || mem_req_ready);
    assign head_ready = load && (sel == last);

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_req_valid <= 1'b0;
            batch_idx     <= '0;
        end else begin
            if (load) begin
                mem_req_valid <= 1'b1;
            end else if (mem_req_ready) begin
                mem_req_valid <= 1'b0;
            end
            if (load) begin
                batch_idx <= head_ready ? '0 : batch_idx_t'(sel + 1'b1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            mem_req <= next_req;
        end
    end

    // A head with no active batch would never leave the queue
    a_head_has_batch: assert property (
        @(posedge clk) disable iff (reset)
        head_valid |-> batch_valid != '0
    );

endmodule

//--- rtl/mem_sched_pkg.sv
// Types shared by the scheduler stages and the testbench.
// Request and response groups travel as packed structs.
`include "mem_sched_settings.svh"

package mem_sched_pkg;

    typedef logic [`MS_WORD_BYTES*8-1:0]                  word_t;
    typedef logic [`MS_ADDR_BITS-1:0]                     addr_t;
    typedef logic [`MS_WORD_BYTES-1:0]                    byteen_t;
    typedef logic [`MS_TAG_BITS-1:0]                      core_tag_t;
    typedef logic [`MS_CORE_REQS-1:0]                     lane_mask_t;
    typedef logic [`MS_MEM_CHANNELS-1:0]                  chan_mask_t;
    typedef logic [`MS_SLOT_BITS-1:0]                     slot_idx_t;
    typedef logic [`MS_BATCH_BITS-1:0]                    batch_idx_t;
    // Slot index in the upper bits, batch index below
    typedef logic [`MS_SLOT_BITS+`MS_BATCH_BITS-1:0]      mem_tag_t;

    typedef struct packed {
        logic                                 rw;
        lane_mask_t                           mask;
        byteen_t [`MS_CORE_REQS-1:0]          byteen;
        addr_t [`MS_CORE_REQS-1:0]            addr;
        word_t [`MS_CORE_REQS-1:0]            data;
        core_tag_t                            tag;
    } core_req_t;

    // Queue entry with the slot index in place of the core tag
    typedef struct packed {
        logic                                 rw;
        lane_mask_t                           mask;
        byteen_t [`MS_CORE_REQS-1:0]          byteen;
        addr_t [`MS_CORE_REQS-1:0]            addr;
        word_t [`MS_CORE_REQS-1:0]            data;
        slot_idx_t                            slot;
    } queued_req_t;

    typedef struct packed {
        logic                                 rw;
        chan_mask_t                           mask;
        byteen_t [`MS_MEM_CHANNELS-1:0]       byteen;
        addr_t [`MS_MEM_CHANNELS-1:0]         addr;
        word_t [`MS_MEM_CHANNELS-1:0]         data;
        mem_tag_t                             tag;
    } mem_req_t;

    typedef struct packed {
        chan_mask_t                           mask;
        word_t [`MS_MEM_CHANNELS-1:0]         data;
        mem_tag_t                             tag;
    } mem_rsp_t;

    typedef struct packed {
        lane_mask_t                           mask;
        word_t [`MS_CORE_REQS-1:0]            data;
        core_tag_t                            tag;
    } core_rsp_t;

endpackage

//--- rtl/mem_sched_settings.svh
// Size constants for the memory request scheduler.
// Include wherever a width or a count is needed; the package pulls it in too.
`ifndef MEM_SCHED_SETTINGS_SVH
`define MEM_SCHED_SETTINGS_SVH

// Core and memory lane counts
`define MS_CORE_REQS      4
`define MS_MEM_CHANNELS   2

// Word and tag widths
`define MS_WORD_BYTES     4
`define MS_ADDR_BITS      30
`define MS_TAG_BITS       8

// Storage sizes
`define MS_SLOTS          4
`define MS_QUEUE_DEPTH    4

// Derived
`define MS_BATCHES        (`MS_CORE_REQS / `MS_MEM_CHANNELS)
`define MS_SLOT_BITS      $clog2(`MS_SLOTS)
`define MS_BATCH_BITS     $clog2(`MS_BATCHES)

`endif

//--- rtl/mem_scheduler.sv
// Memory request scheduler top level.
// Queues core requests, issues them as two-lane memory beats and
// returns one core response per read.
`timescale 1ns/1ps

module mem_scheduler
    import mem_sched_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  logic      core_req_valid,
    input  core_req_t core_req,
    output logic      core_req_ready,
    output logic      core_req_empty,
    output logic      core_req_wr_notify,

    output logic      core_rsp_valid,
    output core_rsp_t core_rsp,
    input  logic      core_rsp_ready,

    output logic      mem_req_valid,
    output mem_req_t  mem_req,
    input  logic      mem_req_ready,

    input  logic      mem_rsp_valid,
    input  mem_rsp_t  mem_rsp,
    output logic      mem_rsp_ready
);
    logic        head_valid;
    queued_req_t head;
    logic        head_ready;
    logic        read_alloc;
    slot_idx_t   free_slot;
    logic        slots_full;
    logic        slots_empty;
    slot_idx_t   rsp_slot;
    logic        slot_release;
    core_tag_t   slot_tag;

    req_queue u_req_queue (
        .clk                (clk),
        .reset              (reset),
        .core_req_valid     (core_req_valid),
        .core_req           (core_req),
        .core_req_ready     (core_req_ready),
        .free_slot          (free_slot),
        .slots_full         (slots_full),
        .slots_empty        (slots_empty),
        .read_alloc         (read_alloc),
        .head_valid         (head_valid),
        .head               (head),
        .head_ready         (head_ready),
        .core_req_empty     (core_req_empty),
        .core_req_wr_notify (core_req_wr_notify)
    );

    slot_table u_slot_table (
        .clk          (clk),
        .reset        (reset),
        .read_alloc   (read_alloc),
        .core_tag     (core_req.tag),
        .free_slot    (free_slot),
        .full         (slots_full),
        .empty        (slots_empty),
        .rsp_slot     (rsp_slot),
        .slot_release (slot_release),
        .slot_tag     (slot_tag)
    );

    batch_issue u_batch_issue (
        .clk           (clk),
        .reset         (reset),
        .head_valid    (head_valid),
        .head          (head),
        .head_ready    (head_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready)
    );

    rsp_assembler u_rsp_assembler (
        .clk            (clk),
        .reset          (reset),
        .read_alloc     (read_alloc),
        .free_slot      (free_slot),
        .alloc_mask     (core_req.mask),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp),
        .mem_rsp_ready  (mem_rsp_ready),
        .rsp_slot       (rsp_slot),
        .slot_release   (slot_release),
        .slot_tag       (slot_tag),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready)
    );

endmodule

//--- rtl/req_queue.sv
// Request FIFO in front of the batch walk.
// Reads are only taken while a response slot is free; the slot index
// replaces the core tag in the stored entry.
`timescale 1ns/1ps
`include "mem_sched_settings.svh"

module req_queue
    import mem_sched_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        core_req_valid,
    input  core_req_t   core_req,
    output logic        core_req_ready,
    input  slot_idx_t   free_slot,
    input  logic        slots_full,
    input  logic        slots_empty,
    output logic        read_alloc,
    output logic        head_valid,
    output queued_req_t head,
    input  logic        head_ready,
    output logic        core_req_empty,
    output logic        core_req_wr_notify
);
    localparam int PTR_BITS = $clog2(`MS_QUEUE_DEPTH);

    queued_req_t fifo_mem [`MS_QUEUE_DEPTH];
    logic [PTR_BITS:0] wr_ptr;
    logic [PTR_BITS:0] rd_ptr;
    logic fifo_full;
    logic fifo_empty;
    logic push;
    logic pop;
    queued_req_t entry;

    // Extra pointer bit tells full from empty
    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full  = (wr_ptr[PTR_BITS] != rd_ptr[PTR_BITS]) &&
                        (wr_ptr[PTR_BITS-1:0] == rd_ptr[PTR_BITS-1:0]);

    // Writes never need a slot
    assign core_req_ready = !fifo_full && (core_req.rw || !slots_full);
    assign push           = core_req_valid && core_req_ready;
    assign read_alloc     = push && !core_req.rw;

    always_comb begin
        entry.rw     = core_req.rw;
        entry.mask   = core_req.mask;
        entry.byteen = core_req.byteen;
        entry.addr   = core_req.addr;
        entry.data   = core_req.data;
        entry.slot   = core_req.rw ? '0 : free_slot;
    end

    assign head_valid = !fifo_empty;
    assign head       = fifo_mem[rd_ptr[PTR_BITS-1:0]];
    assign pop        = head_valid && head_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr[PTR_BITS-1:0]] <= entry;
        end
    end

    // Idle once nothing is queued and every read has been answered
    assign core_req_empty     = fifo_empty && slots_empty;
    assign core_req_wr_notify = pop && head.rw;

    a_req_mask_nonzero: assert property (
        @(posedge clk) disable iff (reset)
        core_req_valid |-> core_req.mask != '0
    );

endmodule

//--- rtl/rsp_assembler.sv
// Gathers memory response beats per slot into one core response.
// A beat fills the lanes of its batch; the beat that clears the last
// outstanding lane loads the output register and frees the slot.
`timescale 1ns/1ps
`include "mem_sched_settings.svh"

module rsp_assembler
    import mem_sched_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       read_alloc,
    input  slot_idx_t  free_slot,
    input  lane_mask_t alloc_mask,
    input  logic       mem_rsp_valid,
    input  mem_rsp_t   mem_rsp,
    output logic       mem_rsp_ready,
    output slot_idx_t  rsp_slot,
    output logic       slot_release,
    input  core_tag_t  slot_tag,
    output logic       core_rsp_valid,
    output core_rsp_t  core_rsp,
    input  logic       core_rsp_ready
);
    lane_mask_t rem_mask [`MS_SLOTS];
    lane_mask_t orig_mask [`MS_SLOTS];
    word_t [`MS_CORE_REQS-1:0] store [`MS_SLOTS];
    batch_idx_t rsp_batch;
    lane_mask_t cur_mask;
    lane_mask_t rem_next;
    word_t [`MS_CORE_REQS-1:0] merged;
    logic complete;
    logic rsp_fire;

    assign rsp_slot  = mem_rsp.tag[`MS_BATCH_BITS +: `MS_SLOT_BITS];
    assign rsp_batch = mem_rsp.tag[`MS_BATCH_BITS-1:0];

    // Lane l belongs to batch l / channels, channel l % channels
    always_comb begin
        merged = store[rsp_slot];
        for (int l = 0; l < `MS_CORE_REQS; l++) begin
            cur_mask[l] = (batch_idx_t'(l / `MS_MEM_CHANNELS) == rsp_batch) &&
                          mem_rsp.mask[l % `MS_MEM_CHANNELS];
            if (cur_mask[l]) begin
                merged[l] = mem_rsp.data[l % `MS_MEM_CHANNELS];
            end
        end
    end

    assign rem_next = rem_mask[rsp_slot] & ~cur_mask;
    assign complete = (rem_next == '0);

    // Only a completing beat needs room in the output register
    assign mem_rsp_ready = !complete || !core_rsp_valid || core_rsp_ready;
    assign rsp_fire      = mem_rsp_valid && mem_rsp_ready;
    assign slot_release  = rsp_fire && complete;

    always_ff @(posedge clk) begin
        if (read_alloc) begin
            rem_mask[free_slot]  <= alloc_mask;
            orig_mask[free_slot] <= alloc_mask;
        end
        if (rsp_fire) begin
            rem_mask[rsp_slot] <= rem_next;
            store[rsp_slot]    <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (slot_release) begin
            core_rsp.mask <= orig_mask[rsp_slot];
            core_rsp.data <= merged;
            core_rsp.tag  <= slot_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            core_rsp_valid <= 1'b0;
        end else if (slot_release) begin
            core_rsp_valid <= 1'b1;
        end else if (core_rsp_ready) begin
            core_rsp_valid <= 1'b0;
        end
    end

    // Memory must not answer a lane twice or a lane nobody asked for
    a_lanes_outstanding: assert property (
        @(posedge clk) disable iff (reset)
        mem_rsp_valid |-> (cur_mask & ~rem_mask[rsp_slot]) == '0
    );

endmodule

//--- rtl/slot_table.sv
// Response slot table for outstanding reads.
// Hands out the lowest free slot, keeps the core tag of each read and
// returns it when the response for that slot is complete.
`timescale 1ns/1ps
`include "mem_sched_settings.svh"

module slot_table
    import mem_sched_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      read_alloc,
    input  core_tag_t core_tag,
    output slot_idx_t free_slot,
    output logic      full,
    output logic      empty,
    input  slot_idx_t rsp_slot,
    input  logic      slot_release,
    output core_tag_t slot_tag
);
    logic [`MS_SLOTS-1:0] busy;
    core_tag_t tag_mem [`MS_SLOTS];

    // Lowest free index wins
    always_comb begin
        free_slot = '0;
        for (int i = `MS_SLOTS - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_slot = slot_idx_t'(i);
            end
        end
    end

    assign full     = &busy;
    assign empty    = ~|busy;
    assign slot_tag = tag_mem[rsp_slot];

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (read_alloc) begin
                busy[free_slot] <= 1'b1;
            end
            if (slot_release) begin
                busy[rsp_slot] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read_alloc) begin
            tag_mem[free_slot] <= core_tag;
        end
    end

    a_release_busy: assert property (
        @(posedge clk) disable iff (reset)
        slot_release |-> busy[rsp_slot]
    );

    // The queue must hold reads back while every slot is taken
    a_no_alloc_full: assert property (
        @(posedge clk) disable iff (reset)
        read_alloc |-> !full
    );

endmodule

//--- src.f
+incdir+rtl
+incdir+tb
rtl/mem_sched_pkg.sv
rtl/req_queue.sv
rtl/slot_table.sv
rtl/batch_issue.sv
rtl/rsp_assembler.sv
rtl/mem_scheduler.sv
tb/tb_mem_scheduler.sv

//--- tb/mem_sched_tb_model.svh
// Reference model functions for the scheduler testbench.
// Included inside the testbench module after the package import.
`ifndef MEM_SCHED_TB_MODEL_SVH
`define MEM_SCHED_TB_MODEL_SVH

// One step of a 32-bit xorshift
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
endfunction

// Data that memory returns for a word address
function automatic word_t mem_data(input addr_t a);
    return word_t'(a) ^ 32'h5a5a_0000;
endfunction

// Beat for batch b of a request with the slot bits of the tag at zero
function automatic mem_req_t expected_beat(input core_req_t req, input int b);
    mem_req_t beat;
    beat = '0;
    beat.rw  = req.rw;
    beat.tag = mem_tag_t'(b);
    for (int c = 0; c < `MS_MEM_CHANNELS; c++) begin
        beat.mask[c]   = req.mask[b*`MS_MEM_CHANNELS + c];
        beat.byteen[c] = req.byteen[b*`MS_MEM_CHANNELS + c];
        beat.addr[c]   = req.addr[b*`MS_MEM_CHANNELS + c];
        beat.data[c]   = req.data[b*`MS_MEM_CHANNELS + c];
    end
    return beat;
endfunction

`endif

//--- tb/tb_mem_scheduler.sv
// Testbench for the memory request scheduler.
// Random core requests, a random out-of-order memory responder and a
// scoreboard that checks beats, read data, write pulses and drain.
`timescale 1ns/1ps
`include "mem_sched_settings.svh"

module tb_mem_scheduler
    import mem_sched_pkg::*;
;
    `include "mem_sched_tb_model.svh"

    localparam int NUM_REQS = 300;
    localparam logic [31:0] SEED = 32'hcb01_79c2;
    localparam int T_RESET = 0;
    localparam int T_SPLIT = 1;
    localparam int T_READ  = 2;
    localparam int T_WRITE = 3;
    localparam int T_BP    = 4;
    localparam int T_DRAIN = 5;

    logic clk;
    logic reset;
    logic core_req_valid;
    core_req_t core_req;
    logic core_req_ready;
    logic core_req_empty;
    logic core_req_wr_notify;
    logic core_rsp_valid;
    core_rsp_t core_rsp;
    logic core_rsp_ready;
    logic mem_req_valid;
    mem_req_t mem_req;
    logic mem_req_ready;
    logic mem_rsp_valid;
    mem_rsp_t mem_rsp;
    logic mem_rsp_ready;

    int errors [6] = '{default: 0};
    int checks = 0;
    logic [31:0] stim_rng = SEED;
    logic [31:0] side_rng = ~SEED;
    // Expected beats in issue order, and read beats waiting for data
    mem_req_t exp_beats [$];
    core_tag_t exp_tags [$];
    mem_req_t pend_beats [$];
    core_tag_t pend_tags [$];
    core_req_t reads_open [core_tag_t];
    int beats_left [core_tag_t];
    int reads_waiting = 0;
    int reads_accepted = 0;
    int reads_answered = 0;
    int writes_accepted = 0;
    int writes_pending = 0;
    int notify_count = 0;
    int beats_checked = 0;
    int rsp_delay = 0;
    core_tag_t drive_tag;

    mem_scheduler dut0 (
        .clk(clk), .reset(reset),
        .core_req_valid(core_req_valid), .core_req(core_req),
        .core_req_ready(core_req_ready), .core_req_empty(core_req_empty),
        .core_req_wr_notify(core_req_wr_notify),
        .core_rsp_valid(core_rsp_valid), .core_rsp(core_rsp),
        .core_rsp_ready(core_rsp_ready),
        .mem_req_valid(mem_req_valid), .mem_req(mem_req), .mem_req_ready(mem_req_ready),
        .mem_rsp_valid(mem_rsp_valid), .mem_rsp(mem_rsp), .mem_rsp_ready(mem_rsp_ready)
    );

    task automatic check_hex(input string name, input logic [63:0] got,
                             input logic [63:0] exp, input int test);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors[test]++;
        end
    endtask

    task automatic check_true(input logic cond, input string what, input int test);
        checks++;
        assert (cond) else begin
            $display("[ERROR] %s", what);
            errors[test]++;
        end
    endtask

    task automatic report_test(input int test, input string title);
        $display("test %0d %s: %s, %0d errors", test + 1, title,
                 errors[test] == 0 ? "ok" : "FAILED", errors[test]);
    endtask

    task automatic make_request(input core_tag_t tag, output core_req_t req);
        req.tag = tag;
        stim_rng = xorshift32(stim_rng);
        req.rw = (stim_rng % 10) >= 6;
        stim_rng = xorshift32(stim_rng);
        req.mask = (stim_rng[3:0] == 4'h0) ? 4'hf : stim_rng[3:0];
        req.byteen = stim_rng[31:16];
        for (int l = 0; l < `MS_CORE_REQS; l++) begin
            stim_rng = xorshift32(stim_rng);
            req.addr[l] = stim_rng[`MS_ADDR_BITS-1:0];
            stim_rng = xorshift32(stim_rng);
            req.data[l] = stim_rng;
        end
    endtask

    task automatic record_request(input core_req_t req);
        mem_req_t beat;
        int beats;
        beats = 0;
        for (int b = 0; b < `MS_BATCHES; b++) begin
            beat = expected_beat(req, b);
            if (beat.mask != '0) begin
                exp_beats.push_back(beat);
                exp_tags.push_back(req.tag);
                beats++;
            end
        end
        if (req.rw) begin
            writes_accepted++;
            writes_pending++;
        end else begin
            reads_accepted++;
            reads_open[req.tag] = req;
            beats_left[req.tag] = beats;
            reads_waiting++;
            check_true(reads_waiting <= `MS_SLOTS, "more than four reads wait for memory", T_BP);
        end
    endtask

    task automatic check_beat();
        mem_req_t exp;
        core_tag_t tag;
        check_true(exp_beats.size() > 0, "memory request with no core request behind it",
                   T_SPLIT);
        if (exp_beats.size() == 0) return;
        exp = exp_beats.pop_front();
        tag = exp_tags.pop_front();
        beats_checked++;
        check_hex("mem_req.rw", mem_req.rw, exp.rw, T_SPLIT);
        check_hex("mem_req.mask", mem_req.mask, exp.mask, T_SPLIT);
        check_hex("mem_req.byteen", mem_req.byteen, exp.byteen, T_SPLIT);
        check_hex("mem_req.addr", mem_req.addr, exp.addr, T_SPLIT);
        check_hex("mem_req.data", mem_req.data, exp.data, T_SPLIT);
        check_hex("mem_req.tag batch", mem_req.tag[`MS_BATCH_BITS-1:0],
                  exp.tag[`MS_BATCH_BITS-1:0], T_SPLIT);
        if (!exp.rw) begin
            pend_beats.push_back(mem_req);
            pend_tags.push_back(tag);
        end
    endtask

    task automatic check_response();
        core_req_t req;
        check_true(reads_open.exists(core_rsp.tag),
                   $sformatf("core response with tag %h matches no open read", core_rsp.tag),
                   T_READ);
        if (!reads_open.exists(core_rsp.tag)) return;
        req = reads_open[core_rsp.tag];
        reads_open.delete(core_rsp.tag);
        reads_answered++;
        check_hex("core_rsp.mask", core_rsp.mask, req.mask, T_READ);
        for (int l = 0; l < `MS_CORE_REQS; l++) begin
            if (req.mask[l]) begin
                check_hex($sformatf("core_rsp.data[%0d]", l), core_rsp.data[l],
                          mem_data(req.addr[l]), T_READ);
            end
        end
    endtask

    // Answers a random waiting beat once the previous one is taken
    task automatic drive_memory_response();
        int idx;
        mem_rsp_t rsp;
        if (mem_rsp_valid && !mem_rsp_ready) return;
        if (pend_beats.size() == 0) return;
        if (rsp_delay > 0) begin
            rsp_delay--;
            return;
        end
        side_rng = xorshift32(side_rng);
        idx = side_rng % pend_beats.size();
        rsp.mask = pend_beats[idx].mask;
        rsp.tag  = pend_beats[idx].tag;
        for (int c = 0; c < `MS_MEM_CHANNELS; c++) begin
            rsp.data[c] = mem_data(pend_beats[idx].addr[c]);
        end
        drive_tag = pend_tags[idx];
        pend_beats.delete(idx);
        pend_tags.delete(idx);
        mem_rsp <= rsp;
        mem_rsp_valid <= 1'b1;
        side_rng = xorshift32(side_rng);
        rsp_delay = side_rng % 4;
    endtask

    function automatic logic drained();
        return exp_beats.size() == 0 && pend_beats.size() == 0 && !mem_rsp_valid &&
               reads_open.num() == 0 && writes_pending == 0;
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Scoreboard and memory side sampled on the rising edge
    always @(posedge clk) begin
        if (!reset) begin
            if (reads_waiting > 0) begin
                check_true(!core_req_empty,
                           "core_req_empty high while reads are outstanding", T_DRAIN);
            end
            if (mem_rsp_valid && !mem_rsp_ready) begin
                check_true(core_rsp_valid && !core_rsp_ready && beats_left[drive_tag] == 1,
                           "memory response stalled with room for a core response", T_BP);
            end
            if (core_req_valid && core_req_ready) begin
                record_request(core_req);
            end
            if (core_req_wr_notify) begin
                check_true(writes_pending > 0, "write notify pulse with no queued write",
                           T_WRITE);
                if (writes_pending > 0) writes_pending--;
                notify_count++;
            end
            if (mem_req_valid && mem_req_ready) begin
                check_beat();
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                beats_left[drive_tag]--;
                if (beats_left[drive_tag] == 0) begin
                    beats_left.delete(drive_tag);
                    reads_waiting--;
                end
                mem_rsp_valid <= 1'b0;
            end
            if (core_rsp_valid && core_rsp_ready) begin
                check_response();
            end
            drive_memory_response();
        end
        side_rng = xorshift32(side_rng);
        mem_req_ready <= (side_rng % 10) >= 3;
        side_rng = xorshift32(side_rng);
        core_rsp_ready <= (side_rng % 10) >= 3;
    end

    initial begin
        repeat (NUM_REQS * 200) @(posedge clk);
        $display("Timeout after %0d cycles, the scheduler did not drain", NUM_REQS * 200);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        core_req_t req;
        core_tag_t next_tag;
        int total;
        reset = 1'b1;
        core_req_valid = 1'b0;
        core_req = '0;
        core_rsp_ready = 1'b0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp = '0;
        next_tag = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_true(!mem_req_valid, "mem_req_valid high after reset", T_RESET);
        check_true(!core_rsp_valid, "core_rsp_valid high after reset", T_RESET);
        check_true(core_req_empty, "core_req_empty low after reset", T_RESET);
        report_test(T_RESET, "reset state");

        for (int i = 0; i < NUM_REQS; i++) begin
            make_request(next_tag, req);
            next_tag++;
            core_req <= req;
            core_req_valid <= 1'b1;
            @(posedge clk);
            while (!core_req_ready) @(posedge clk);
            core_req_valid <= 1'b0;
            stim_rng = xorshift32(stim_rng);
            if (stim_rng[1:0] == 2'b00) @(posedge clk);
        end

        do @(negedge clk); while (!drained());
        repeat (2) @(posedge clk);
        check_true(core_req_empty, "core_req_empty low after drain", T_DRAIN);
        check_true(!mem_req_valid, "memory request left after drain", T_DRAIN);
        check_true(!core_rsp_valid, "core response left after drain", T_DRAIN);
        check_hex("reads answered", reads_answered, reads_accepted, T_READ);
        check_hex("write notify count", notify_count, writes_accepted, T_WRITE);
        report_test(T_SPLIT, $sformatf("batch splitting, %0d beats", beats_checked));
        report_test(T_READ, $sformatf("read responses, %0d reads", reads_answered));
        report_test(T_WRITE, $sformatf("write notify, %0d writes", notify_count));
        report_test(T_BP, "back-pressure and slot limit");
        report_test(T_DRAIN, "drain");

        total = 0;
        for (int t = 0; t < 6; t++) begin
            total += errors[t];
        end
        $display("%0d checks, %0d errors", checks, total);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
